// File: logic/decoderPkg.sv
package decoderPkg;

    localparam int instWidth   = 16;
    localparam int regIdxWidth = 3;
    localparam int opcodeWidth = 5;
    localparam int dataWidth   = 16;

    // Major opcodes, bits 15:11
    localparam logic [opcodeWidth-1:0] opcNop    = 5'b00001;
    localparam logic [opcodeWidth-1:0] opcB      = 5'b00010;
    localparam logic [opcodeWidth-1:0] opcBeqz   = 5'b00100;
    localparam logic [opcodeWidth-1:0] opcBnez   = 5'b00101;
    localparam logic [opcodeWidth-1:0] opcShift  = 5'b00110;
    localparam logic [opcodeWidth-1:0] opcAddiu3 = 5'b01000;
    localparam logic [opcodeWidth-1:0] opcAddiu  = 5'b01001;
    localparam logic [opcodeWidth-1:0] opcLi     = 5'b01101;
    localparam logic [opcodeWidth-1:0] opcLw     = 5'b10011;
    localparam logic [opcodeWidth-1:0] opcSw     = 5'b11011;
    localparam logic [opcodeWidth-1:0] opcAddSub = 5'b11100;
    localparam logic [opcodeWidth-1:0] opcAlu    = 5'b11101;

    // Shift and AddSub groups look at bits 1:0 only
    localparam logic [1:0] functSll  = 2'b00;
    localparam logic [1:0] functSra  = 2'b11;
    localparam logic [1:0] functAddu = 2'b01;
    localparam logic [1:0] functSubu = 2'b11;

    // ALU group, bits 4:0
    localparam logic [4:0] functAnd     = 5'b01100;
    localparam logic [4:0] functOr      = 5'b01101;
    localparam logic [4:0] functNot     = 5'b01111;
    localparam logic [4:0] functSllv    = 5'b00100;
    localparam logic [4:0] functSrav    = 5'b00111;
    localparam logic [4:0] functJrGroup = 5'b00000;

    typedef struct packed {
        logic [opcodeWidth-1:0] opcode;
        logic [regIdxWidth-1:0] rx;
        logic [regIdxWidth-1:0] ry;
        logic [regIdxWidth-1:0] rz;
        logic [1:0]             funct;
    } regView_t;

    typedef struct packed {
        logic [opcodeWidth-1:0] opcode;
        logic [regIdxWidth-1:0] rx;
        logic [7:0]             imm8;
    } immView_t;

    // Same word, read as register fields or as an immediate
    typedef union packed {
        regView_t regView;
        immView_t immView;
    } instWord_u;

    typedef enum logic [4:0] {
        kindNop,
        kindB,
        kindBeqz,
        kindBnez,
        kindSll,
        kindSra,
        kindAddiu3,
        kindAddiu,
        kindLi,
        kindLw,
        kindSw,
        kindAddu,
        kindSubu,
        kindAnd,
        kindOr,
        kindNot,
        kindSllv,
        kindSrav,
        kindJr,
        kindIllegal
    } instKind_e;

    typedef enum logic [3:0] {
        opAdd     = 4'b0000,
        opSub     = 4'b0001,
        opAnd     = 4'b0010,
        opOr      = 4'b0011,
        opNot     = 4'b0100,
        opSra     = 4'b0101,
        opSll     = 4'b0110,
        opBranch  = 4'b1000,
        opPassA   = 4'b1001,
        opTestNez = 4'b1010,
        opLoadImm = 4'b1100
    } aluOp_e;

    typedef enum logic [3:0] {
        immNone   = 4'b0000,
        immZext8  = 4'b0001,
        immShift3 = 4'b0101,
        immSext8  = 4'b1000,
        immSext4  = 4'b1001,
        immSext5  = 4'b1010,
        immSext11 = 4'b1011
    } immKind_e;

    typedef enum logic [1:0] {
        dstRx = 2'b00,
        dstRy = 2'b01,
        dstRz = 2'b10
    } regDst_e;

    typedef enum logic [1:0] {
        srcARx = 2'b00,
        srcARy = 2'b10
    } aluSrcA_e;

    typedef enum logic [1:0] {
        srcBRy  = 2'b00,
        srcBImm = 2'b01,
        srcBRx  = 2'b10
    } aluSrcB_e;

    typedef struct packed {
        instKind_e kind;
        instWord_u word;
    } classified_t;

    typedef struct packed {
        logic                   illegal;
        aluOp_e                 aluOp;
        aluSrcA_e               aluSrcA;
        aluSrcB_e               aluSrcB;
        logic                   memRead;
        logic                   memWrite;
        logic                   memToReg;
        logic                   regWrite;
        logic                   branch;
        logic                   jump;
        logic [regIdxWidth-1:0] destReg;
        logic [dataWidth-1:0]   immValue;
    } decoded_t;

endpackage

// File: logic/instClassifier.sv
module instClassifier (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    inReq,
    output logic                    inAck,
    input  decoderPkg::instWord_u   inInst,
    output logic                    classReq,
    input  logic                    classAck,
    output decoderPkg::classified_t classData
);

    logic                  full;
    logic                  accept;
    decoderPkg::instKind_e kind;

    // Only an empty stage takes a new word
    assign accept = inReq && !inAck && !full;

    always_comb
    begin
        kind = decoderPkg::kindIllegal;
        case (inInst.regView.opcode)
            decoderPkg::opcNop:
            begin
                // Everything below the opcode must be zero
                if (inInst[decoderPkg::instWidth-decoderPkg::opcodeWidth-1:0] == '0)
                begin
                    kind = decoderPkg::kindNop;
                end
            end
            decoderPkg::opcB:      kind = decoderPkg::kindB;
            decoderPkg::opcBeqz:   kind = decoderPkg::kindBeqz;
            decoderPkg::opcBnez:   kind = decoderPkg::kindBnez;
            decoderPkg::opcAddiu3: kind = decoderPkg::kindAddiu3;
            decoderPkg::opcAddiu:  kind = decoderPkg::kindAddiu;
            decoderPkg::opcLi:     kind = decoderPkg::kindLi;
            decoderPkg::opcLw:     kind = decoderPkg::kindLw;
            decoderPkg::opcSw:     kind = decoderPkg::kindSw;
            decoderPkg::opcShift:
            begin
                case (inInst.regView.funct)
                    decoderPkg::functSll: kind = decoderPkg::kindSll;
                    decoderPkg::functSra: kind = decoderPkg::kindSra;
                    default:              kind = decoderPkg::kindIllegal;
                endcase
            end
            decoderPkg::opcAddSub:
            begin
                case (inInst.regView.funct)
                    decoderPkg::functAddu: kind = decoderPkg::kindAddu;
                    decoderPkg::functSubu: kind = decoderPkg::kindSubu;
                    default:               kind = decoderPkg::kindIllegal;
                endcase
            end
            decoderPkg::opcAlu:
            begin
                // Subfunction spans rz and funct
                case ({inInst.regView.rz, inInst.regView.funct})
                    decoderPkg::functAnd:  kind = decoderPkg::kindAnd;
                    decoderPkg::functOr:   kind = decoderPkg::kindOr;
                    decoderPkg::functNot:  kind = decoderPkg::kindNot;
                    decoderPkg::functSllv: kind = decoderPkg::kindSllv;
                    decoderPkg::functSrav: kind = decoderPkg::kindSrav;
                    decoderPkg::functJrGroup:
                    begin
                        // JR only with ry clear, the rest were PC moves
                        if (inInst.regView.ry == '0)
                        begin
                            kind = decoderPkg::kindJr;
                        end
                    end
                    default: kind = decoderPkg::kindIllegal;
                endcase
            end
            default:
            begin
                kind = decoderPkg::kindIllegal;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            full     <= 1'b0;
            inAck    <= 1'b0;
            classReq <= 1'b0;
        end
        else if (accept)
        begin
            full     <= 1'b1;
            inAck    <= 1'b1;
            classReq <= 1'b1;
        end
        else
        begin
            if (inAck && !inReq)
            begin
                inAck <= 1'b0;
            end
            if (classReq && classAck)
            begin
                classReq <= 1'b0;
            end
            // Downstream done and upstream released
            if (full && !classReq && !classAck && !inAck)
            begin
                full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            classData.kind <= kind;
            classData.word <= inInst;
        end
    end

endmodule

// File: logic/controlExpander.sv
module controlExpander (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    classReq,
    output logic                    classAck,
    input  decoderPkg::classified_t classData,
    output logic                    outReq,
    input  logic                    outAck,
    output decoderPkg::decoded_t    outData
);

    logic                               full;
    logic                               accept;
    decoderPkg::instKind_e              kind;
    decoderPkg::instWord_u              word;
    decoderPkg::immKind_e               immKind;
    decoderPkg::regDst_e                regDst;
    logic [decoderPkg::regIdxWidth-1:0] destReg;
    logic [decoderPkg::dataWidth-1:0]   immValue;
    decoderPkg::decoded_t               nextOut;

    assign accept = classReq && !classAck && !full;
    assign kind   = classData.kind;
    assign word   = classData.word;

    // Control table, one field at a time
    always_comb
    begin
        nextOut = '0;
        case (kind)
            decoderPkg::kindB:                     nextOut.aluOp = decoderPkg::opBranch;
            decoderPkg::kindBeqz, decoderPkg::kindJr: nextOut.aluOp = decoderPkg::opPassA;
            decoderPkg::kindBnez:                  nextOut.aluOp = decoderPkg::opTestNez;
            decoderPkg::kindSll, decoderPkg::kindSllv: nextOut.aluOp = decoderPkg::opSll;
            decoderPkg::kindSra, decoderPkg::kindSrav: nextOut.aluOp = decoderPkg::opSra;
            decoderPkg::kindLi:                    nextOut.aluOp = decoderPkg::opLoadImm;
            decoderPkg::kindSubu:                  nextOut.aluOp = decoderPkg::opSub;
            decoderPkg::kindAnd:                   nextOut.aluOp = decoderPkg::opAnd;
            decoderPkg::kindOr:                    nextOut.aluOp = decoderPkg::opOr;
            decoderPkg::kindNot:                   nextOut.aluOp = decoderPkg::opNot;
            default:                               nextOut.aluOp = decoderPkg::opAdd;
        endcase
        case (kind)
            decoderPkg::kindSll, decoderPkg::kindSra, decoderPkg::kindSllv, decoderPkg::kindSrav:
                nextOut.aluSrcA = decoderPkg::srcARy;
            default:
                nextOut.aluSrcA = decoderPkg::srcARx;
        endcase
        case (kind)
            decoderPkg::kindSll, decoderPkg::kindSra, decoderPkg::kindAddiu3,
            decoderPkg::kindAddiu, decoderPkg::kindLi, decoderPkg::kindLw, decoderPkg::kindSw:
                nextOut.aluSrcB = decoderPkg::srcBImm;
            decoderPkg::kindSllv, decoderPkg::kindSrav:
                nextOut.aluSrcB = decoderPkg::srcBRx;
            default:
                nextOut.aluSrcB = decoderPkg::srcBRy;
        endcase
        nextOut.illegal  = (kind == decoderPkg::kindIllegal);
        nextOut.memRead  = (kind == decoderPkg::kindLw);
        nextOut.memToReg = (kind == decoderPkg::kindLw);
        nextOut.memWrite = (kind == decoderPkg::kindSw);
        nextOut.jump     = (kind == decoderPkg::kindJr);
        nextOut.branch   = kind inside {decoderPkg::kindB, decoderPkg::kindBeqz,
                                        decoderPkg::kindBnez};
        nextOut.regWrite = !(kind inside {decoderPkg::kindNop, decoderPkg::kindB,
                                          decoderPkg::kindBeqz, decoderPkg::kindBnez,
                                          decoderPkg::kindSw, decoderPkg::kindJr,
                                          decoderPkg::kindIllegal});
        // Illegal words carry no register index
        nextOut.destReg  = nextOut.illegal ? '0 : destReg;
        nextOut.immValue = immValue;
    end

    always_comb
    begin
        case (kind)
            decoderPkg::kindB:                     immKind = decoderPkg::immSext11;
            decoderPkg::kindBeqz, decoderPkg::kindBnez,
            decoderPkg::kindAddiu:                 immKind = decoderPkg::immSext8;
            decoderPkg::kindSll, decoderPkg::kindSra: immKind = decoderPkg::immShift3;
            decoderPkg::kindAddiu3:                immKind = decoderPkg::immSext4;
            decoderPkg::kindLi:                    immKind = decoderPkg::immZext8;
            decoderPkg::kindLw, decoderPkg::kindSw: immKind = decoderPkg::immSext5;
            default:                               immKind = decoderPkg::immNone;
        endcase
        case (kind)
            decoderPkg::kindAddiu3, decoderPkg::kindLw,
            decoderPkg::kindSllv, decoderPkg::kindSrav: regDst = decoderPkg::dstRy;
            decoderPkg::kindAddu, decoderPkg::kindSubu: regDst = decoderPkg::dstRz;
            default:                                   regDst = decoderPkg::dstRx;
        endcase
    end

    always_comb
    begin
        case (regDst)
            decoderPkg::dstRy: destReg = word.regView.ry;
            decoderPkg::dstRz: destReg = word.regView.rz;
            default:           destReg = word.regView.rx;
        endcase
    end

    always_comb
    begin
        case (immKind)
            decoderPkg::immZext8:
                immValue = {{(decoderPkg::dataWidth-8){1'b0}}, word.immView.imm8};
            decoderPkg::immShift3:
                // Shift amount of zero encodes 8
                immValue = (word.regView.rz == '0) ? decoderPkg::dataWidth'(8) :
                           decoderPkg::dataWidth'(word.regView.rz);
            decoderPkg::immSext8:
                immValue = {{(decoderPkg::dataWidth-8){word.immView.imm8[7]}},
                            word.immView.imm8};
            decoderPkg::immSext4:
                immValue = {{(decoderPkg::dataWidth-4){word.immView.imm8[3]}},
                            word.immView.imm8[3:0]};
            decoderPkg::immSext5:
                immValue = {{(decoderPkg::dataWidth-5){word.immView.imm8[4]}},
                            word.immView.imm8[4:0]};
            decoderPkg::immSext11:
                immValue = {{(decoderPkg::dataWidth-11){word.immView.rx[2]}},
                            word.immView.rx, word.immView.imm8};
            default:
                immValue = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            full     <= 1'b0;
            classAck <= 1'b0;
            outReq   <= 1'b0;
            outData  <= '0;
        end
        else if (accept)
        begin
            full     <= 1'b1;
            classAck <= 1'b1;
            outReq   <= 1'b1;
            outData  <= nextOut;
        end
        else
        begin
            if (classAck && !classReq)
            begin
                classAck <= 1'b0;
            end
            if (outReq && outAck)
            begin
                outReq <= 1'b0;
            end
            if (full && !outReq && !outAck && !classAck)
            begin
                full <= 1'b0;
            end
        end
    end

endmodule

// File: logic/instDecoder.sv
module instDecoder (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  inReq,
    output logic                  inAck,
    input  decoderPkg::instWord_u inInst,
    output logic                  outReq,
    input  logic                  outAck,
    output decoderPkg::decoded_t  outData
);

    // Channel between the two stages
    logic                    classReq;
    logic                    classAck;
    decoderPkg::classified_t classData;

    instClassifier u_classifier (
        .clk       (clk),
        .rstN      (rstN),
        .inReq     (inReq),
        .inAck     (inAck),
        .inInst    (inInst),
        .classReq  (classReq),
        .classAck  (classAck),
        .classData (classData)
    );

    controlExpander u_expander (
        .clk       (clk),
        .rstN      (rstN),
        .classReq  (classReq),
        .classAck  (classAck),
        .classData (classData),
        .outReq    (outReq),
        .outAck    (outAck),
        .outData   (outData)
    );

endmodule

// File: verification/instDecoder_props.sv
module instDecoderProps (
    input logic                  clk,
    input logic                  rstN,
    input logic                  inReq,
    input logic                  inAck,
    input decoderPkg::instWord_u inInst,
    input logic                  classReq,
    input logic                  classAck,
    input logic                  outReq,
    input logic                  outAck,
    input decoderPkg::decoded_t  outData
);

    logic quietQ;
    logic idleStart;
    logic startQ1;
    logic startQ2;

    // Request seen by an empty pipeline
    assign idleStart = inReq && !inAck && quietQ;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            quietQ  <= 1'b0;
            startQ1 <= 1'b0;
            startQ2 <= 1'b0;
        end
        else
        begin
            quietQ  <= !inAck && !classReq && !classAck && !outReq && !outAck;
            startQ1 <= idleStart;
            startQ2 <= startQ1;
        end
    end

    inInstHeld: assert property (@(posedge clk) disable iff (!rstN)
        (inReq && !inAck) |=> (!inReq || $stable(inInst)))
        else $error("inInst changed while inReq waited for inAck");

    outDataHeld: assert property (@(posedge clk) disable iff (!rstN)
        (outReq && !outAck) |=> $stable(outData))
        else $error("outData changed while outReq waited for outAck");

    outReqHeld: assert property (@(posedge clk) disable iff (!rstN)
        $fell(outReq) |-> $past(outAck))
        else $error("outReq fell before outAck rose");

    inAckHeld: assert property (@(posedge clk) disable iff (!rstN)
        $fell(inAck) |-> !$past(inReq))
        else $error("inAck fell while inReq was still high");

    idleLatency: assert property (@(posedge clk) disable iff (!rstN)
        startQ2 |-> $rose(outReq))
        else $error("outReq did not rise two edges after a request into an empty pipeline");

endmodule

bind instDecoder instDecoderProps u_props (
    .clk      (clk),
    .rstN     (rstN),
    .inReq    (inReq),
    .inAck    (inAck),
    .inInst   (inInst),
    .classReq (classReq),
    .classAck (classAck),
    .outReq   (outReq),
    .outAck   (outAck),
    .outData  (outData)
);

// File: verification/instDecoderTb.sv
module instDecoderTb;

    localparam int numDirected   = 19;
    localparam int numRandom     = 400;
    localparam int numOrder      = 100;
    // Worst case is about 10 cycles per word with outAck held back
    localparam int timeoutCycles = 12 * (numDirected + numRandom + numOrder) + 100;

    logic                  clk = 1'b0;
    logic                  rstN;
    logic                  inReq;
    logic                  inAck;
    decoderPkg::instWord_u inInst;
    logic                  outReq;
    logic                  outAck;
    decoderPkg::decoded_t  outData;

    logic [15:0] lfsrState = 16'd31;
    logic [15:0] sendList[$];
    logic [15:0] expectList[$];
    int          errorCount = 0;
    int          checkCount = 0;
    int          received;
    int          cycleCount = 0;

    instDecoder u_dut (
        .clk     (clk),
        .rstN    (rstN),
        .inReq   (inReq),
        .inAck   (inAck),
        .inInst  (inInst),
        .outReq  (outReq),
        .outAck  (outAck),
        .outData (outData)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount >= timeoutCycles)
        begin
            $display("Timeout after %0d cycles, the decoder stopped answering", cycleCount);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit
    function automatic logic [15:0] takeBits(input int count);
        logic [15:0] value;
        int          i;
        value = '0;
        for (i = 0; i < count; i++)
        begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
            value = {value[14:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic logic [4:0] keptOpcode(input int idx);
        case (idx)
            0:       return decoderPkg::opcNop;
            1:       return decoderPkg::opcB;
            2:       return decoderPkg::opcBeqz;
            3:       return decoderPkg::opcBnez;
            4:       return decoderPkg::opcShift;
            5:       return decoderPkg::opcAddiu3;
            6:       return decoderPkg::opcAddiu;
            7:       return decoderPkg::opcLi;
            8:       return decoderPkg::opcLw;
            9:       return decoderPkg::opcSw;
            10:      return decoderPkg::opcAddSub;
            default: return decoderPkg::opcAlu;
        endcase
    endfunction

    function automatic logic [4:0] aluFunct(input int idx);
        case (idx)
            0:       return decoderPkg::functAnd;
            1:       return decoderPkg::functOr;
            2:       return decoderPkg::functNot;
            3:       return decoderPkg::functSllv;
            4:       return decoderPkg::functSrav;
            default: return decoderPkg::functJrGroup;
        endcase
    endfunction

    function automatic logic [15:0] randomWord();
        logic [4:0]  op;
        logic [10:0] low;
        if (takeBits(3) == 16'd0)
            op = 5'(takeBits(5));
        else
            op = keptOpcode(int'(takeBits(4) % 16'd12));
        low = 11'(takeBits(11));
        // Roughly a third get a legal subfunction
        if (takeBits(6) % 16'd3 == 16'd0)
        begin
            case (op)
                decoderPkg::opcShift:
                    low[1:0] = (takeBits(1) != 16'd0) ? decoderPkg::functSll :
                               decoderPkg::functSra;
                decoderPkg::opcAddSub:
                    low[1:0] = (takeBits(1) != 16'd0) ? decoderPkg::functAddu :
                               decoderPkg::functSubu;
                decoderPkg::opcAlu:
                begin
                    low[4:0] = aluFunct(int'(takeBits(3) % 16'd6));
                    if (low[4:0] == decoderPkg::functJrGroup)
                        low[7:5] = 3'b000;
                end
                default:
                    low = low;
            endcase
        end
        return {op, low};
    endfunction

    // Distinct rx, ry and rz fields plus sign bits and the zero shift
    function automatic logic [15:0] directedWord(input int idx);
        case (idx)
            0:       return 16'h0800;
            1:       return 16'h1405;
            2:       return 16'h2180;
            3:       return 16'h297F;
            4:       return 16'h3140;
            5:       return 16'h314F;
            6:       return 16'h4158;
            7:       return 16'h49F0;
            8:       return 16'h69F0;
            9:       return 16'h9951;
            10:      return 16'hD94F;
            11:      return 16'hE151;
            12:      return 16'hE153;
            13:      return 16'hE94C;
            14:      return 16'hE94D;
            15:      return 16'hE94F;
            16:      return 16'hE944;
            17:      return 16'hE947;
            default: return 16'hE900;
        endcase
    endfunction

    function automatic string modelName(input logic [15:0] w);
        string name;
        name = "ILLEGAL";
        case (w[15:11])
            5'b00001:
                if (w[10:0] == 11'd0)
                    name = "NOP";
            5'b00010: name = "B";
            5'b00100: name = "BEQZ";
            5'b00101: name = "BNEZ";
            5'b01000: name = "ADDIU3";
            5'b01001: name = "ADDIU";
            5'b01101: name = "LI";
            5'b10011: name = "LW";
            5'b11011: name = "SW";
            5'b00110:
                if (w[1:0] == 2'b00)
                    name = "SLL";
                else if (w[1:0] == 2'b11)
                    name = "SRA";
            5'b11100:
                if (w[1:0] == 2'b01)
                    name = "ADDU";
                else if (w[1:0] == 2'b11)
                    name = "SUBU";
            5'b11101:
                case (w[4:0])
                    5'b01100: name = "AND";
                    5'b01101: name = "OR";
                    5'b01111: name = "NOT";
                    5'b00100: name = "SLLV";
                    5'b00111: name = "SRAV";
                    5'b00000:
                        if (w[7:5] == 3'b000)
                            name = "JR";
                    default:  name = "ILLEGAL";
                endcase
            default: name = "ILLEGAL";
        endcase
        return name;
    endfunction

    // Flags are memRead memWrite memToReg regWrite branch jump
    function automatic decoderPkg::decoded_t makeRow(input logic [3:0] op, input logic [1:0] srcA,
        input logic [1:0] srcB, input logic [5:0] flags, input logic [2:0] dst,
        input logic [15:0] imm);
        decoderPkg::decoded_t d;
        d = '0;
        d.aluOp    = decoderPkg::aluOp_e'(op);
        d.aluSrcA  = decoderPkg::aluSrcA_e'(srcA);
        d.aluSrcB  = decoderPkg::aluSrcB_e'(srcB);
        {d.memRead, d.memWrite, d.memToReg, d.regWrite, d.branch, d.jump} = flags;
        d.destReg  = dst;
        d.immValue = imm;
        return d;
    endfunction

    function automatic decoderPkg::decoded_t modelDecode(input logic [15:0] w);
        decoderPkg::decoded_t d;
        logic [2:0]  rx;
        logic [2:0]  ry;
        logic [2:0]  rz;
        logic [15:0] shamt;
        rx    = w[10:8];
        ry    = w[7:5];
        rz    = w[4:2];
        shamt = (rz == 3'd0) ? 16'd8 : {13'd0, rz};
        d     = '0;
        case (modelName(w))
            "NOP":    d = makeRow(4'b0000, 2'b00, 2'b00, 6'b000000, rx, 16'h0000);
            "B":      d = makeRow(4'b1000, 2'b00, 2'b00, 6'b000010, rx, {{5{w[10]}}, w[10:0]});
            "BEQZ":   d = makeRow(4'b1001, 2'b00, 2'b00, 6'b000010, rx, {{8{w[7]}}, w[7:0]});
            "BNEZ":   d = makeRow(4'b1010, 2'b00, 2'b00, 6'b000010, rx, {{8{w[7]}}, w[7:0]});
            "SLL":    d = makeRow(4'b0110, 2'b10, 2'b01, 6'b000100, rx, shamt);
            "SRA":    d = makeRow(4'b0101, 2'b10, 2'b01, 6'b000100, rx, shamt);
            "ADDIU3": d = makeRow(4'b0000, 2'b00, 2'b01, 6'b000100, ry, {{12{w[3]}}, w[3:0]});
            "ADDIU":  d = makeRow(4'b0000, 2'b00, 2'b01, 6'b000100, rx, {{8{w[7]}}, w[7:0]});
            "LI":     d = makeRow(4'b1100, 2'b00, 2'b01, 6'b000100, rx, {8'h00, w[7:0]});
            "LW":     d = makeRow(4'b0000, 2'b00, 2'b01, 6'b101100, ry, {{11{w[4]}}, w[4:0]});
            "SW":     d = makeRow(4'b0000, 2'b00, 2'b01, 6'b010000, rx, {{11{w[4]}}, w[4:0]});
            "ADDU":   d = makeRow(4'b0000, 2'b00, 2'b00, 6'b000100, rz, 16'h0000);
            "SUBU":   d = makeRow(4'b0001, 2'b00, 2'b00, 6'b000100, rz, 16'h0000);
            "AND":    d = makeRow(4'b0010, 2'b00, 2'b00, 6'b000100, rx, 16'h0000);
            "OR":     d = makeRow(4'b0011, 2'b00, 2'b00, 6'b000100, rx, 16'h0000);
            "NOT":    d = makeRow(4'b0100, 2'b00, 2'b00, 6'b000100, rx, 16'h0000);
            "SLLV":   d = makeRow(4'b0110, 2'b10, 2'b10, 6'b000100, ry, 16'h0000);
            "SRAV":   d = makeRow(4'b0101, 2'b10, 2'b10, 6'b000100, ry, 16'h0000);
            "JR":     d = makeRow(4'b1001, 2'b00, 2'b00, 6'b000001, rx, 16'h0000);
            default:  d.illegal = 1'b1;
        endcase
        return d;
    endfunction

    task automatic checkField(input string field, input logic [15:0] word,
        input logic [15:0] expected, input logic [15:0] actual);
        checkCount++;
        assert (actual === expected)
        else
        begin
            errorCount++;
            $display("CHECK FAILED %s expected 0x%h actual 0x%h (word 0x%h %s)",
                     field, expected, actual, word, modelName(word));
        end
    endtask

    task automatic checkDecoded(input logic [15:0] word, input decoderPkg::decoded_t got);
        decoderPkg::decoded_t exp;
        exp = modelDecode(word);
        checkField("outData.illegal", word, 16'(exp.illegal), 16'(got.illegal));
        checkField("outData.aluOp", word, 16'(exp.aluOp), 16'(got.aluOp));
        checkField("outData.aluSrcA", word, 16'(exp.aluSrcA), 16'(got.aluSrcA));
        checkField("outData.aluSrcB", word, 16'(exp.aluSrcB), 16'(got.aluSrcB));
        checkField("outData.memRead", word, 16'(exp.memRead), 16'(got.memRead));
        checkField("outData.memWrite", word, 16'(exp.memWrite), 16'(got.memWrite));
        checkField("outData.memToReg", word, 16'(exp.memToReg), 16'(got.memToReg));
        checkField("outData.regWrite", word, 16'(exp.regWrite), 16'(got.regWrite));
        checkField("outData.branch", word, 16'(exp.branch), 16'(got.branch));
        checkField("outData.jump", word, 16'(exp.jump), 16'(got.jump));
        checkField("outData.destReg", word, 16'(exp.destReg), 16'(got.destReg));
        checkField("outData.immValue", word, exp.immValue, got.immValue);
    endtask

    task automatic sendWords();
        logic [15:0] word;
        while (sendList.size() > 0)
        begin
            word = sendList.pop_front();
            inInst = word;
            inReq  = 1'b1;
            expectList.push_back(word);
            do @(negedge clk); while (!inAck);
            inReq = 1'b0;
            do @(negedge clk); while (inAck);
        end
    endtask

    task automatic receiveWords(input int count);
        logic [15:0] word;
        int          delay;
        while (received < count)
        begin
            do @(negedge clk); while (!outReq);
            delay = int'(takeBits(2));
            repeat (delay) @(negedge clk);
            assert (expectList.size() > 0)
            else
            begin
                errorCount++;
                $display("Decoder produced an output with no word pending");
            end
            if (expectList.size() > 0)
            begin
                word = expectList.pop_front();
                checkDecoded(word, outData);
            end
            outAck = 1'b1;
            do @(negedge clk); while (outReq);
            outAck = 1'b0;
            received++;
        end
    endtask

    task automatic runBatch(input string name, input int count);
        int errorsBefore;
        int checksBefore;
        errorsBefore = errorCount;
        checksBefore = checkCount;
        received     = 0;
        fork
            sendWords();
            receiveWords(count);
        join
        repeat (4) @(negedge clk);
        assert (!outReq && expectList.size() == 0)
        else
        begin
            errorCount++;
            $display("%s: %0d words in but %0d out, %0d left pending",
                     name, count, received, expectList.size());
        end
        $display("%s: %0d words, %0d checks, %0d errors", name, count,
                 checkCount - checksBefore, errorCount - errorsBefore);
    endtask

    task automatic checkReset();
        int errorsBefore;
        errorsBefore = errorCount;
        checkField("inAck", 16'h0, 16'h0, 16'(inAck));
        checkField("outReq", 16'h0, 16'h0, 16'(outReq));
        checkCount++;
        assert (outData === '0)
        else
        begin
            errorCount++;
            $display("CHECK FAILED outData expected 0x0 actual 0x%h", outData);
        end
        $display("reset state: 3 checks, %0d errors", errorCount - errorsBefore);
    endtask

    initial
    begin
        int i;
        rstN   = 1'b0;
        inReq  = 1'b0;
        inInst = '0;
        outAck = 1'b0;
        repeat (5) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        checkReset();

        for (i = 0; i < numDirected; i++)
            sendList.push_back(directedWord(i));
        runBatch("directed decode", numDirected);

        for (i = 0; i < numRandom; i++)
            sendList.push_back(randomWord());
        runBatch("random decode", numRandom);

        for (i = 0; i < numOrder; i++)
            sendList.push_back(randomWord());
        runBatch("order under back-pressure", numOrder);

        $display("total: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: instDecoder.f
logic/decoderPkg.sv
logic/instClassifier.sv
logic/controlExpander.sv
logic/instDecoder.sv
verification/instDecoder_props.sv
verification/instDecoderTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= instDecoderTb
RTL_TOP   ?= instDecoder
FILELIST  ?= instDecoder.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

RTL_SRCS ?= logic/decoderPkg.sv logic/instClassifier.sv logic/controlExpander.sv \
            logic/instDecoder.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
